//--- ahci_rx_pkg.sv
/*
 * Shared definitions for the AHCI FIS receive path.
 * Register offsets are DWORD addresses into the HBA register space.
 * Every receive block imports this package inside its module body.
 */
package ahci_rx_pkg;

    localparam int reg_addr_bits = 10;                 // dword address width of register space

    typedef logic [reg_addr_bits-1:0] reg_addr_t;
    typedef logic [31:0]              dword_t;
    typedef logic [3:0]               dcount_t;        // dword index / count inside one fis
    typedef logic [11:0]              dwcount_t;       // dma payload dwords

    typedef enum logic [1:0] {
        dtype_data = 2'd0,                             // payload dword
        dtype_head = 2'd1,                             // first dword of a fis
        dtype_rok  = 2'd2,                             // end of fis, crc good
        dtype_rerr = 2'd3                              // end of fis, crc bad
    } dtype_t;

    typedef enum logic [2:0] {
        fis_none,
        fis_rfis,                                      // d2h register fis
        fis_sdbfis,                                    // set device bits
        fis_ufis,                                      // unknown fis, stored raw
        fis_data,                                      // data fis, payload to dma
        fis_ignore                                     // read and drop
    } fis_kind_t;

    localparam reg_addr_t fb_offs     = 10'h300;       // received fis area
    localparam reg_addr_t rfis_offs   = 10'h010;
    localparam reg_addr_t sdbfis_offs = 10'h016;
    localparam reg_addr_t ufis_offs   = 10'h018;
    localparam reg_addr_t pxtfd_offs  = 10'h048;       // port 0 task file data
    localparam reg_addr_t pxsig_offs  = 10'h049;       // port 0 signature

    localparam dcount_t rfis_lenm1   = 4'd4;
    localparam dcount_t sdbfis_lenm1 = 4'd1;
    localparam dcount_t ufis_lenm1   = 4'd15;
    localparam dcount_t datah_lenm1  = 4'd0;           // data fis has a single header dword
    localparam dcount_t ignore_lenm1 = 4'd15;

endpackage

//--- fis_frame_ctl.sv
/*
 * Frames one incoming FIS from the transport FIFO.
 * Raises fis_first_vld on a waiting head, then on a get_* pulse walks the
 * header dwords, hands them to the store and field logic and closes the
 * FIS on the end tag. Payload of a data FIS is taken by the DMA forwarder.
 */
module fis_frame_ctl (
    input  logic                   mclk,
    input  logic                   hba_rst,
    input  ahci_rx_pkg::dtype_t    hba_data_in_type,
    input  logic                   hba_data_in_valid,
    input  logic                   hba_data_in_many,
    input  logic                   get_rfis,
    input  logic                   get_sdbfis,
    input  logic                   get_ufis,
    input  logic                   get_data_fis,
    input  logic                   get_ignore,
    input  logic                   pcmd_fre,
    input  logic                   pupdate_sig,
    input  logic                   dma_take,
    input  logic                   skip_take,
    input  logic                   too_long,
    output logic                   hba_data_in_ready,
    output logic                   fis_first_vld,
    output logic                   get_fis_busy,
    output logic                   get_fis_done,
    output logic                   fis_ok,
    output logic                   fis_err,
    output logic                   fis_ferr,
    output logic                   store_we,
    output ahci_rx_pkg::reg_addr_t store_addr,
    output ahci_rx_pkg::dcount_t   word_idx,
    output ahci_rx_pkg::fis_kind_t fis_kind,
    output logic                   word_take,
    output logic                   dma_start,
    output logic                   data_in_ready
);
    import ahci_rx_pkg::*;

    logic [1:0] hold_cnt;           // fifo output not trusted while nonzero
    logic       fis_rec_run;        // between get_* and end tag
    logic       fis_save;           // header dwords go to register space
    logic       dwords_over;        // all header dwords taken
    dcount_t    fis_lenm1;
    reg_addr_t  fis_base;
    fis_kind_t  get_kind;
    logic       get_fis;
    logic       is_fis_end;
    logic       over_take;          // dword past the fis length, dropped
    logic       end_pulse;          // end tag taken

    assign get_fis    = get_rfis | get_sdbfis | get_ufis | get_data_fis | get_ignore;
    assign is_fis_end = (hba_data_in_type == dtype_rok) || (hba_data_in_type == dtype_rerr);

    assign data_in_ready = hba_data_in_valid && (hold_cnt == 2'd0);
    assign word_take     = fis_rec_run && data_in_ready && !is_fis_end && !dwords_over;
    assign over_take     = fis_rec_run && data_in_ready && !is_fis_end && dwords_over &&
                           (fis_kind != fis_data);   // data payload belongs to dma side
    assign end_pulse     = fis_rec_run && data_in_ready && is_fis_end;

    assign hba_data_in_ready = word_take | over_take | end_pulse | dma_take | skip_take;

    assign store_we   = word_take && fis_save;
    assign store_addr = fis_base + reg_addr_t'(word_idx);
    assign dma_start  = word_take && (fis_kind == fis_data);

    always_comb begin
        get_kind = fis_none;
        if (get_rfis)          get_kind = fis_rfis;
        else if (get_sdbfis)   get_kind = fis_sdbfis;
        else if (get_ufis)     get_kind = fis_ufis;
        else if (get_data_fis) get_kind = fis_data;
        else if (get_ignore)   get_kind = fis_ignore;
    end

    // fifo output updates late: after a single-word read wait two cycles
    always_ff @(posedge mclk) begin
        if (hba_rst)                hold_cnt <= 2'd0;
        else if (hba_data_in_ready) hold_cnt <= hba_data_in_many ? 2'd0 : 2'd2;
        else if (hold_cnt != 2'd0)  hold_cnt <= hold_cnt - 2'd1;
    end

    always_ff @(posedge mclk) begin
        if (get_fis) begin
            word_idx <= '0;
            // a d2h fis is kept while a signature is pending, others obey fre
            fis_save <= (pupdate_sig && get_rfis) || (pcmd_fre && !get_data_fis && !get_ignore);
            case (get_kind)
                fis_rfis: begin
                    fis_base  <= fb_offs + rfis_offs;
                    fis_lenm1 <= rfis_lenm1;
                end
                fis_sdbfis: begin
                    fis_base  <= fb_offs + sdbfis_offs;
                    fis_lenm1 <= sdbfis_lenm1;
                end
                fis_ufis: begin
                    fis_base  <= fb_offs + ufis_offs;
                    fis_lenm1 <= ufis_lenm1;
                end
                fis_data: begin
                    fis_base  <= fb_offs;             // never stored
                    fis_lenm1 <= datah_lenm1;
                end
                default: begin
                    fis_base  <= fb_offs;
                    fis_lenm1 <= ignore_lenm1;
                end
            endcase
        end else if (word_take) begin
            word_idx <= word_idx + dcount_t'(1);
        end
    end

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            fis_rec_run   <= 1'b0;
            get_fis_busy  <= 1'b0;
            get_fis_done  <= 1'b0;
            fis_ok        <= 1'b0;
            fis_err       <= 1'b0;
            fis_ferr      <= 1'b0;
            fis_first_vld <= 1'b0;
            dwords_over   <= 1'b0;
            fis_kind      <= fis_none;
        end else begin
            if (get_fis)        fis_rec_run <= 1'b1;
            else if (end_pulse) fis_rec_run <= 1'b0;

            if (get_fis)                                  get_fis_busy <= 1'b1;
            else if (end_pulse || over_take || too_long)  get_fis_busy <= 1'b0;

            get_fis_done <= get_fis_busy && (end_pulse || over_take || too_long);

            if (get_fis) begin
                fis_ok  <= 1'b0;
                fis_err <= 1'b0;
            end else if (end_pulse && get_fis_busy) begin
                fis_ok  <= hba_data_in_type == dtype_rok;
                fis_err <= hba_data_in_type == dtype_rerr;
            end

            if (over_take || too_long) fis_ferr <= 1'b1;   // fatal, held until reset

            if (get_fis)
                fis_first_vld <= 1'b0;
            else if (!fis_rec_run && data_in_ready && (hba_data_in_type == dtype_head))
                fis_first_vld <= 1'b1;

            if (get_fis)                                 dwords_over <= 1'b0;
            else if (word_take && word_idx == fis_lenm1) dwords_over <= 1'b1;

            if (get_fis) fis_kind <= get_kind;
        end
    end

endmodule

//--- dma_in_fwd.sv
/*
 * Passes data FIS payload dwords from the FIFO to the DMA engine.
 * Counts forwarded dwords and drains words the DMA no longer wants.
 */
module dma_in_fwd (
    input  logic                  mclk,
    input  logic                  hba_rst,
    input  ahci_rx_pkg::dtype_t   hba_data_in_type,
    input  logic                  data_in_ready,
    input  logic                  dma_start,
    input  logic                  dma_in_ready,
    input  logic                  dma_prds_done,
    output logic                  dma_in_valid,
    output logic                  dma_take,
    output logic                  skip_take,
    output ahci_rx_pkg::dwcount_t data_in_dwords,
    output logic                  fis_extra,
    output logic                  too_long
);
    import ahci_rx_pkg::*;

    logic active;       // inside data fis payload
    logic is_data;      // payload dword on fifo output
    logic drain;        // drop payload instead of forwarding

    assign is_data = data_in_ready && (hba_data_in_type == dtype_data);
    // 2048 dwords is the longest legal payload
    assign drain   = fis_extra || too_long || dma_prds_done || data_in_dwords[11];

    assign dma_take     = active && is_data && !drain && dma_in_ready;
    assign skip_take    = active && is_data && drain;
    assign dma_in_valid = dma_take;

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            active         <= 1'b0;
            fis_extra      <= 1'b0;
            too_long       <= 1'b0;
            data_in_dwords <= '0;
        end else begin
            if (dma_start)
                active <= 1'b1;
            else if (data_in_ready && hba_data_in_type != dtype_data)
                active <= 1'b0;                          // end tag reached

            if (dma_start)                              fis_extra <= 1'b0;
            else if (active && is_data && dma_prds_done) fis_extra <= 1'b1;

            if (active && is_data && data_in_dwords[11]) too_long <= 1'b1;

            if (dma_start)     data_in_dwords <= '0;
            else if (dma_take) data_in_dwords <= data_in_dwords + dwcount_t'(1);
        end
    end

endmodule

//--- tfd_sig_regs.sv
/*
 * Task file status/error, FIS flag bits and device signature.
 * Fields load from header dwords as they are taken from the FIFO.
 * Signature capture is armed by set_update_sig and closed by update_sig.
 */
module tfd_sig_regs (
    input  logic                   mclk,
    input  logic                   hba_rst,
    input  ahci_rx_pkg::dword_t    hba_data_in,
    input  logic                   word_take,
    input  ahci_rx_pkg::dcount_t   word_idx,
    input  ahci_rx_pkg::fis_kind_t fis_kind,
    input  logic                   set_update_sig,
    input  logic                   update_sig,
    output logic [7:0]             tfd_sts,
    output logic [7:0]             tfd_err,
    output logic                   fis_i,
    output logic                   sdb_n,
    output logic                   sactive0,
    output logic                   pupdate_sig,
    output logic                   sig_available,
    output ahci_rx_pkg::dword_t    sig_word
);
    import ahci_rx_pkg::*;

    logic [15:0] tfd_word;      // {error, status}
    logic        rfis_w0;
    logic        rfis_w1;
    logic        rfis_w3;
    logic        sdb_w0;
    logic        sdb_w1;

    assign rfis_w0 = word_take && (fis_kind == fis_rfis) && (word_idx == dcount_t'(0));
    assign rfis_w1 = word_take && (fis_kind == fis_rfis) && (word_idx == dcount_t'(1));
    assign rfis_w3 = word_take && (fis_kind == fis_rfis) && (word_idx == dcount_t'(3));
    assign sdb_w0  = word_take && (fis_kind == fis_sdbfis) && (word_idx == dcount_t'(0));
    assign sdb_w1  = word_take && (fis_kind == fis_sdbfis) && (word_idx == dcount_t'(1));

    assign tfd_sts = tfd_word[7:0];
    assign tfd_err = tfd_word[15:8];

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            tfd_word <= '0;
            fis_i    <= 1'b0;
            sdb_n    <= 1'b0;
            sactive0 <= 1'b0;
        end else begin
            if (rfis_w0)
                tfd_word <= hba_data_in[31:16];          // error 31:24, status 23:16
            else if (sdb_w0)                             // sdb leaves bsy/drq-area bits 7 and 3
                tfd_word <= {hba_data_in[15:8], tfd_word[7], hba_data_in[6:4],
                             tfd_word[3], hba_data_in[2:0]};

            if (rfis_w0 || sdb_w0) fis_i    <= hba_data_in[14];
            if (sdb_w0)            sdb_n    <= hba_data_in[15];
            if (sdb_w1)            sactive0 <= hba_data_in[0];
        end
    end

    always_ff @(posedge mclk) begin
        if (hba_rst || set_update_sig) pupdate_sig <= 1'b1;
        else if (update_sig)           pupdate_sig <= 1'b0;

        if (hba_rst || update_sig)       sig_available <= 1'b0;
        else if (rfis_w3 && pupdate_sig) sig_available <= 1'b1;   // last signature byte in
    end

    always_ff @(posedge mclk) begin
        if (rfis_w1 && pupdate_sig) sig_word[31:8] <= hba_data_in[23:0];   // lba high/mid/low
        if (rfis_w3 && pupdate_sig) sig_word[7:0]  <= hba_data_in[7:0];    // sector count
    end

endmodule

//--- reg_wr_mux.sv
/*
 * Single registered write port into the HBA register space.
 * FIS stores win; PxTFD and PxSIG updates land two cycles after their pulse.
 */
module reg_wr_mux (
    input  logic                   mclk,
    input  logic                   hba_rst,
    input  logic                   store_we,
    input  ahci_rx_pkg::reg_addr_t store_addr,
    input  ahci_rx_pkg::dword_t    hba_data_in,
    input  logic                   update_err_sts,
    input  logic                   update_sig,
    input  logic                   pupdate_sig,
    input  logic [7:0]             tfd_sts,
    input  logic [7:0]             tfd_err,
    input  ahci_rx_pkg::dword_t    sig_word,
    output ahci_rx_pkg::reg_addr_t reg_addr,
    output logic                   reg_we,
    output ahci_rx_pkg::dword_t    reg_data
);
    import ahci_rx_pkg::*;

    logic upd_tfd_r;    // pxtfd write pending
    logic upd_sig_r;    // pxsig write pending

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            upd_tfd_r <= 1'b0;
            upd_sig_r <= 1'b0;
            reg_we    <= 1'b0;
        end else begin
            upd_tfd_r <= update_err_sts;
            upd_sig_r <= update_sig && pupdate_sig;     // no signature write unless armed
            reg_we    <= store_we || upd_tfd_r || upd_sig_r;
        end
    end

    always_ff @(posedge mclk) begin
        if (store_we) begin
            reg_addr <= store_addr;
            reg_data <= hba_data_in;
        end else if (upd_tfd_r) begin
            reg_addr <= pxtfd_offs;
            reg_data <= {16'h0000, tfd_err, tfd_sts};
        end else if (upd_sig_r) begin
            reg_addr <= pxsig_offs;
            reg_data <= sig_word;
        end
    end

endmodule

//--- ahci_fis_receive.sv
/*
 * AHCI port receive side for incoming FIS frames.
 * Connects FIS framing, DMA forwarding, task file/signature fields
 * and the register write port.
 */
module ahci_fis_receive (
    input  logic                   mclk,
    input  logic                   hba_rst,
    output logic                   fis_first_vld,
    input  logic                   get_rfis,
    input  logic                   get_sdbfis,
    input  logic                   get_ufis,
    input  logic                   get_data_fis,
    input  logic                   get_ignore,
    output logic                   get_fis_busy,
    output logic                   get_fis_done,
    output logic                   fis_ok,
    output logic                   fis_err,
    output logic                   fis_ferr,
    input  logic                   dma_prds_done,
    output logic                   fis_extra,
    input  logic                   set_update_sig,
    output logic                   pupdate_sig,
    output logic                   sig_available,
    input  logic                   update_sig,
    input  logic                   update_err_sts,
    input  logic                   pcmd_fre,
    output logic [7:0]             tfd_sts,
    output logic [7:0]             tfd_err,
    output logic                   fis_i,
    output logic                   sdb_n,
    output logic                   sactive0,
    output ahci_rx_pkg::dwcount_t  data_in_dwords,
    output ahci_rx_pkg::reg_addr_t reg_addr,
    output logic                   reg_we,
    output ahci_rx_pkg::dword_t    reg_data,
    input  ahci_rx_pkg::dword_t    hba_data_in,
    input  ahci_rx_pkg::dtype_t    hba_data_in_type,
    input  logic                   hba_data_in_valid,
    input  logic                   hba_data_in_many,
    output logic                   hba_data_in_ready,
    input  logic                   dma_in_ready,
    output logic                   dma_in_valid
);
    import ahci_rx_pkg::*;

    logic      store_we;
    reg_addr_t store_addr;
    dcount_t   word_idx;
    fis_kind_t fis_kind;
    logic      word_take;
    logic      dma_start;
    logic      data_in_ready;   // fifo word may be read this cycle
    logic      dma_take;
    logic      skip_take;
    logic      too_long;
    dword_t    sig_word;

    fis_frame_ctl i_fis_frame_ctl (.*);

    dma_in_fwd i_dma_in_fwd (.*);

    tfd_sig_regs i_tfd_sig_regs (.*);

    reg_wr_mux i_reg_wr_mux (.*);

endmodule

//--- tb_ahci_fis_receive.sv
/*
 * Testbench for the AHCI FIS receive path.
 * A stream driver feeds tagged dwords, a reference function predicts writes,
 * task file fields, signature, flags and DMA words, and a checker compares.
 */
module tb_ahci_fis_receive;
    timeunit 1ns;
    timeprecision 1ps;
    import ahci_rx_pkg::*;

    localparam int k_rfis   = 0;
    localparam int k_sdb    = 1;
    localparam int k_ufis   = 2;
    localparam int k_data   = 3;
    localparam int wait_max = 400;      // cycles per wait loop

    logic      mclk = 1'b0;
    logic      hba_rst = 1'b1;
    logic      get_rfis = 1'b0;
    logic      get_sdbfis = 1'b0;
    logic      get_ufis = 1'b0;
    logic      get_data_fis = 1'b0;
    logic      get_ignore = 1'b0;
    logic      dma_prds_done = 1'b0;
    logic      set_update_sig = 1'b0;
    logic      update_sig = 1'b0;
    logic      update_err_sts = 1'b0;
    logic      pcmd_fre = 1'b0;
    dword_t    hba_data_in = '0;
    dtype_t    hba_data_in_type = dtype_data;
    logic      hba_data_in_valid = 1'b0;
    logic      hba_data_in_many = 1'b0;
    logic      dma_in_ready = 1'b0;
    logic      fis_first_vld, get_fis_busy, get_fis_done;
    logic      fis_ok, fis_err, fis_ferr, fis_extra;
    logic      pupdate_sig, sig_available, fis_i, sdb_n, sactive0;
    logic [7:0] tfd_sts, tfd_err;
    dwcount_t  data_in_dwords;
    reg_addr_t reg_addr;
    logic      reg_we;
    dword_t    reg_data;
    logic      hba_data_in_ready, dma_in_valid;

    logic [33:0] stream_q[$];           // {tag, dword} waiting in the fifo
    dword_t      fis_q[$];              // current fis from the head on without end tag
    reg_addr_t   exp_wr_addr[$];
    dword_t      exp_wr_data[$];
    dword_t      exp_dma[$];
    bit          exp_ok, exp_err, exp_ferr, exp_extra;
    int          exp_dwords;
    logic [7:0]  m_sts, m_err;          // model of the task file
    bit          m_fis_i, m_sdbn, m_sact, m_sig_pend, m_sig_avail, m_ferr;
    bit          m_prds_done = 1'b0;    // dma has no more prd space
    dword_t      m_sig;
    int          seed = 35;
    int          err_cnt = 0;
    int          fail_cnt = 0;
    int          chk_err_cnt = 0;       // counted by the checker process
    int          chk_fail_cnt = 0;
    string       test_name = "none";

    ahci_fis_receive i_ahci_fis_receive (.*);

    initial begin
        forever #5 mclk = ~mclk;        // 100 MHz
    end

    // fifo model pops a word when ready was high at the edge
    always @(posedge mclk) begin
        int rnd;
        if (hba_data_in_ready && stream_q.size() > 0)
            void'(stream_q.pop_front());
        if (stream_q.size() > 0) begin
            hba_data_in_valid <= 1'b1;
            hba_data_in_type  <= dtype_t'(stream_q[0][33:32]);
            hba_data_in       <= stream_q[0][31:0];
            hba_data_in_many  <= (stream_q.size() >= 2);
        end else begin
            hba_data_in_valid <= 1'b0;
            hba_data_in_many  <= 1'b0;
        end
        rnd = $random(seed);
        dma_in_ready <= rnd[0];         // random dma back-pressure
    end

    // in-order checker for register writes and dma transfers
    always @(posedge mclk) begin
        if (reg_we) begin
            if (exp_wr_addr.size() == 0) begin
                $display("%s: unexpected register write %h = %h", test_name, reg_addr, reg_data);
                chk_fail_cnt++;
            end else begin
                if (reg_addr !== exp_wr_addr[0] || reg_data !== exp_wr_data[0]) begin
                    $display("ERR %s reg write: expected %h = %h, actual %h = %h", test_name,
                             exp_wr_addr[0], exp_wr_data[0], reg_addr, reg_data);
                    chk_err_cnt++;
                end
                void'(exp_wr_addr.pop_front());
                void'(exp_wr_data.pop_front());
            end
        end
        if (dma_in_valid) begin
            if (exp_dma.size() == 0) begin
                $display("%s: unexpected dma word %h", test_name, hba_data_in);
                chk_fail_cnt++;
            end else begin
                if (hba_data_in !== exp_dma[0]) begin
                    $display("ERR %s dma word: expected %h, actual %h", test_name,
                             exp_dma[0], hba_data_in);
                    chk_err_cnt++;
                end
                void'(exp_dma.pop_front());
            end
        end
    end

    function automatic void clear_model();
        m_sts       = 8'h00;
        m_err       = 8'h00;
        m_fis_i     = 1'b0;
        m_sdbn      = 1'b0;
        m_sact      = 1'b0;
        m_sig_pend  = 1'b1;             // signature wanted after reset
        m_sig_avail = 1'b0;
        m_ferr      = 1'b0;
    endfunction

    // expected writes, dma words, flags and fields for fis_q of one kind
    function automatic void ref_fis(input int kind, input bit fre, input bit end_err);
        int        i;
        int        len;
        bit        save;
        bit        over;
        reg_addr_t base;
        dword_t    w0;
        len  = 16;
        save = 1'b0;
        base = fb_offs;
        w0   = fis_q[0];
        case (kind)
            k_rfis: begin
                len  = 5;
                base = fb_offs + rfis_offs;
                save = fre || m_sig_pend;   // pending signature keeps the d2h fis
            end
            k_sdb: begin
                len  = 2;
                base = fb_offs + sdbfis_offs;
                save = fre;
            end
            k_ufis: begin
                len  = 16;
                base = fb_offs + ufis_offs;
                save = fre;
            end
            k_data:  len = 1;               // only the header dword is framed
            default: len = 16;
        endcase
        over = (kind != k_data) && (fis_q.size() > len);
        for (i = 0; i < fis_q.size() && i < len; i++) begin
            if (save) begin
                exp_wr_addr.push_back(base + reg_addr_t'(i));
                exp_wr_data.push_back(fis_q[i]);
            end
        end
        exp_dwords = 0;
        exp_extra  = 1'b0;
        if (kind == k_data && m_prds_done) begin
            exp_extra = fis_q.size() > 1;   // payload after prds done is drained
        end else if (kind == k_data) begin
            for (i = 1; i < fis_q.size(); i++)
                exp_dma.push_back(fis_q[i]);
            exp_dwords = fis_q.size() - 1;
        end
        exp_ok   = !over && !end_err;
        exp_err  = !over && end_err;
        m_ferr   = m_ferr || over;      // sticky
        exp_ferr = m_ferr;
        if (kind == k_rfis) begin
            m_sts   = w0[23:16];
            m_err   = w0[31:24];
            m_fis_i = w0[14];
            if (m_sig_pend) begin
                m_sig       = {fis_q[1][23:0], fis_q[3][7:0]};
                m_sig_avail = 1'b1;
            end
        end else if (kind == k_sdb) begin
            m_err   = w0[15:8];
            m_sts   = {m_sts[7], w0[6:4], m_sts[3], w0[2:0]};   // bits 7 and 3 held
            m_fis_i = w0[14];
            m_sdbn  = w0[15];
            m_sact  = fis_q[1][0];
        end
    endfunction

    task automatic compare_val(input string what, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        if (act_v !== exp_v) begin
            $display("ERR %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
            err_cnt++;
        end
    endtask

    task automatic report_fail(input string why);
        $display("%s: %s", test_name, why);
        fail_cnt++;
    endtask

    task automatic apply_reset();
        hba_rst <= 1'b1;
        repeat (8) @(posedge mclk);
        hba_rst <= 1'b0;
    endtask

    task automatic wait_drained();
        int t;
        t = 0;
        while ((stream_q.size() > 0 || exp_wr_addr.size() > 0 || exp_dma.size() > 0)
               && t < wait_max) begin
            @(posedge mclk);
            t++;
        end
        if (t >= wait_max)
            report_fail("timed out waiting for the stream and expected writes to drain");
    endtask

    // queue fis_q with its end tag, hand it to the DUT and check the outcome
    task automatic run_fis(input int kind, input bit fre, input bit end_err);
        int     i;
        int     t;
        dtype_t tag;
        ref_fis(kind, fre, end_err);
        for (i = 0; i < fis_q.size(); i++) begin
            tag = (i == 0) ? dtype_head : dtype_data;
            stream_q.push_back({tag, fis_q[i]});
        end
        tag = end_err ? dtype_rerr : dtype_rok;
        stream_q.push_back({tag, 32'h0000_0000});
        @(posedge mclk);
        pcmd_fre <= fre;
        t = 0;
        while (!fis_first_vld && t < wait_max) begin
            @(posedge mclk);
            t++;
        end
        if (t >= wait_max)
            report_fail("timed out waiting for fis_first_vld");
        case (kind)
            k_rfis:  get_rfis     <= 1'b1;
            k_sdb:   get_sdbfis   <= 1'b1;
            k_ufis:  get_ufis     <= 1'b1;
            k_data:  get_data_fis <= 1'b1;
            default: get_ignore   <= 1'b1;
        endcase
        @(posedge mclk);
        get_rfis     <= 1'b0;
        get_sdbfis   <= 1'b0;
        get_ufis     <= 1'b0;
        get_data_fis <= 1'b0;
        get_ignore   <= 1'b0;
        t = 0;
        while (!get_fis_done && t < wait_max) begin
            @(posedge mclk);
            t++;
        end
        if (t >= wait_max) begin
            report_fail("timed out waiting for get_fis_done");
        end else begin
            compare_val("fis_ok", 32'(exp_ok), 32'(fis_ok));
            compare_val("fis_err", 32'(exp_err), 32'(fis_err));
            compare_val("fis_ferr", 32'(exp_ferr), 32'(fis_ferr));
        end
        wait_drained();
        compare_val("tfd_sts", 32'(m_sts), 32'(tfd_sts));
        compare_val("tfd_err", 32'(m_err), 32'(tfd_err));
        compare_val("fis_i", 32'(m_fis_i), 32'(fis_i));
        compare_val("sdb_n", 32'(m_sdbn), 32'(sdb_n));
        compare_val("sactive0", 32'(m_sact), 32'(sactive0));
        compare_val("sig_available", 32'(m_sig_avail), 32'(sig_available));
        if (kind == k_data) begin
            compare_val("data_in_dwords", 32'(exp_dwords), 32'(data_in_dwords));
            compare_val("fis_extra", 32'(exp_extra), 32'(fis_extra));
        end
    endtask

    initial begin
        int i;
        clear_model();
        apply_reset();

        test_name = "d2h_store";
        fis_q = '{32'h0150_4034, 32'h00a1_b2c3, 32'h1111_2222, 32'h0000_0044, 32'h0000_0000};
        run_fis(k_rfis, 1'b1, 1'b0);

        test_name = "sig_capture";
        exp_wr_addr.push_back(pxsig_offs);      // signature left by the first d2h fis
        exp_wr_data.push_back(m_sig);
        m_sig_pend  = 1'b0;
        m_sig_avail = 1'b0;
        @(posedge mclk);
        update_sig <= 1'b1;
        @(posedge mclk);
        update_sig <= 1'b0;
        wait_drained();
        compare_val("pupdate_sig", 32'h0, 32'(pupdate_sig));
        @(posedge mclk);
        set_update_sig <= 1'b1;
        @(posedge mclk);
        set_update_sig <= 1'b0;
        m_sig_pend = 1'b1;
        fis_q = '{32'h0489_4034, 32'h0000_0001, 32'h0000_0000, 32'h0000_0001, 32'h0000_0000};
        run_fis(k_rfis, 1'b0, 1'b0);            // kept although fre is low
        exp_wr_addr.push_back(pxsig_offs);
        exp_wr_data.push_back(m_sig);
        m_sig_pend  = 1'b0;
        m_sig_avail = 1'b0;
        @(posedge mclk);
        update_sig <= 1'b1;
        @(posedge mclk);
        update_sig <= 1'b0;
        wait_drained();
        compare_val("pupdate_sig", 32'h0, 32'(pupdate_sig));
        compare_val("sig_available", 32'h0, 32'(sig_available));
        fis_q = '{32'h0289_0034, 32'h00de_adbe, 32'h0000_0000, 32'h0000_0077, 32'h0000_0000};
        run_fis(k_rfis, 1'b0, 1'b0);            // nothing stored now

        test_name = "sdb_bits";
        fis_q = '{32'h0000_c155, 32'h0000_0001};
        run_fis(k_sdb, 1'b1, 1'b0);
        exp_wr_addr.push_back(pxtfd_offs);
        exp_wr_data.push_back({16'h0000, m_err, m_sts});
        @(posedge mclk);
        update_err_sts <= 1'b1;
        @(posedge mclk);
        update_err_sts <= 1'b0;
        wait_drained();

        test_name = "data_dma";
        fis_q = '{32'h0000_0046};
        for (i = 0; i < 40; i++)
            fis_q.push_back(32'hd000_0000 + 32'h0101_0101 * i);
        run_fis(k_data, 1'b1, 1'b0);

        test_name = "data_prds_done";
        @(posedge mclk);
        dma_prds_done <= 1'b1;
        m_prds_done = 1'b1;
        fis_q = '{32'h0000_0046, 32'hc0de_0001, 32'hc0de_0002, 32'hc0de_0003};
        run_fis(k_data, 1'b1, 1'b0);            // payload drained, not forwarded
        @(posedge mclk);
        dma_prds_done <= 1'b0;
        m_prds_done = 1'b0;

        test_name = "end_err";
        fis_q = '{32'h0051_0034, 32'h0000_0002, 32'h0000_0003, 32'h0000_0004, 32'h0000_0005};
        run_fis(k_rfis, 1'b1, 1'b1);

        test_name = "ufis_long";
        fis_q = '{32'h0000_00ee};
        for (i = 1; i <= 18; i++)
            fis_q.push_back(32'h5a00_0000 + i);     // three dwords past the limit
        run_fis(k_ufis, 1'b1, 1'b0);

        test_name = "reset_values";
        apply_reset();
        clear_model();
        @(posedge mclk);
        compare_val("reg_we", 32'h0, 32'(reg_we));
        compare_val("get_fis_busy", 32'h0, 32'(get_fis_busy));
        compare_val("get_fis_done", 32'h0, 32'(get_fis_done));
        compare_val("fis_ok", 32'h0, 32'(fis_ok));
        compare_val("fis_err", 32'h0, 32'(fis_err));
        compare_val("fis_ferr", 32'h0, 32'(fis_ferr));
        compare_val("fis_extra", 32'h0, 32'(fis_extra));
        compare_val("dma_in_valid", 32'h0, 32'(dma_in_valid));
        compare_val("hba_data_in_ready", 32'h0, 32'(hba_data_in_ready));
        compare_val("fis_first_vld", 32'h0, 32'(fis_first_vld));
        compare_val("sig_available", 32'h0, 32'(sig_available));
        compare_val("pupdate_sig", 32'h1, 32'(pupdate_sig));
        compare_val("tfd_sts", 32'h0, 32'(tfd_sts));
        compare_val("data_in_dwords", 32'h0, 32'(data_in_dwords));

        $display("errors: %0d wrong values, %0d other failures",
                 err_cnt + chk_err_cnt, fail_cnt + chk_fail_cnt);
        if (err_cnt + chk_err_cnt + fail_cnt + chk_fail_cnt == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

//--- tb.f
ahci_rx_pkg.sv
fis_frame_ctl.sv
dma_in_fwd.sv
tfd_sig_regs.sv
reg_wr_mux.sv
ahci_fis_receive.sv
tb_ahci_fis_receive.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
TOP       := tb_ahci_fis_receive
FILELIST  := tb.f
BUILD     := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove build output and log"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test FAILED" $(LOG) || ! grep -q "Test OK" $(LOG); then \
		echo "simulation reported failure"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
